//--- rv_pkg.sv
package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and reset values
    //////////////////////////////////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;

    // RV32I major opcodes kept by this core
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////////////////////////

    // Opcode, rd, rs1 and rs2 share their bit positions in all views
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic                  imm12;
        logic [5:0]            imm10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm4_1;
        logic                  imm11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    //////////////////////////////////////////////////////////////////////
    // Port bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic [rv_pkg::reg_addr_w-1:0]   rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0]   rs2_addr,
    output logic [rv_pkg::xlen-1:0]         rs1_data,
    output logic [rv_pkg::xlen-1:0]         rs2_data,
    input  rv_pkg::rf_write_t               rf_wr
);

    import rv_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rf_wr.en && (rf_wr.addr != '0)) begin
            regs[rf_wr.addr] <= rf_wr.data;
        end
    end

    // Combinational reads with x0 forced to zero
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != '0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    output rv_pkg::mem_req_t        fetch_req,
    input  logic                    fetch_ack,
    input  logic [rv_pkg::xlen-1:0] rdata,
    output logic                    inst_valid,
    output rv_pkg::instr_u          inst,
    output logic [rv_pkg::xlen-1:0] inst_pc,
    input  logic                    inst_take,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] redirect_pc
);

    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] issue_addr;
    logic [xlen-1:0] buf_pc;
    logic            req_valid;
    logic            buf_valid;
    logic            discard;
    logic            issue;
    instr_u          buf_inst;

    // One fetch outstanding at most, so the buffer is always free at its ack
    assign issue      = !req_valid && (!buf_valid || inst_take || redirect);
    assign issue_addr = redirect ? redirect_pc : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= reset_pc;
            req_valid <= 1'b0;
            buf_valid <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (issue) begin
                req_valid <= 1'b1;
                pc        <= issue_addr + xlen'(4);
            end else if (redirect) begin
                pc <= redirect_pc;
            end
            if (fetch_ack) begin
                req_valid <= 1'b0;
            end
            if (redirect || inst_take) begin
                buf_valid <= 1'b0;
            end
            // A wrong-path word is dropped rather than buffered
            if (fetch_ack && !discard && !redirect) begin
                buf_valid <= 1'b1;
            end
            if (fetch_ack) begin
                discard <= 1'b0;
            end else if (redirect && req_valid) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= issue_addr;
        end
        if (fetch_ack) begin
            buf_inst <= rdata;
            buf_pc   <= req_addr;
        end
    end

    assign fetch_req  = '{valid: req_valid, we: 1'b0, addr: req_addr, wdata: '0};
    assign inst_valid = buf_valid;
    assign inst       = buf_inst;
    assign inst_pc    = buf_pc;

    take_needs_valid: assert property (
        @(posedge clk) disable iff (reset) inst_take |-> inst_valid
    );

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inst_valid,
    input  rv_pkg::instr_u                inst,
    input  logic [rv_pkg::xlen-1:0]       inst_pc,
    output logic                          inst_take,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    output rv_pkg::rf_write_t             rf_wr,
    output rv_pkg::mem_req_t              data_req,
    input  logic                          data_ack,
    input  logic [rv_pkg::xlen-1:0]       rdata,
    output logic                          redirect,
    output logic [rv_pkg::xlen-1:0]       redirect_pc
);

    import rv_pkg::*;

    typedef enum logic {st_idle, st_mem_wait} state_e;

    state_e                state;
    alu_op_e               alu_op;
    logic [6:0]            opcode;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       operand_b;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       branch_target;
    logic                  rs_equal;
    logic                  branch_taken;
    logic                  is_mem;
    logic                  writes_rd;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;
    logic                  req_valid;
    logic                  req_we;
    logic [xlen-1:0]       req_addr;
    logic [xlen-1:0]       req_wdata;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign opcode   = inst.r.opcode;
    assign rd       = inst.r.rd;
    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    always_comb begin
        alu_op = alu_add;
        case (opcode)
            op_reg, op_imm: begin
                case (inst.r.funct3)
                    3'b111:  alu_op = alu_and;
                    3'b110:  alu_op = alu_or;
                    3'b100:  alu_op = alu_xor;
                    default: alu_op = (opcode == op_reg && inst.r.funct7[5]) ? alu_sub : alu_add;
                endcase
            end
            op_lui:  alu_op = alu_pass_b;
            default: alu_op = alu_add;
        endcase
    end

    // Immediate from whichever format view the opcode selects
    always_comb begin
        case (opcode)
            op_store:  imm = {{(xlen-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            op_lui:    imm = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'b0};
            op_branch: imm = {{(xlen-13){inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                              inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            default:   imm = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // ALU and branch resolution
    //////////////////////////////////////////////////////////////////////

    assign operand_b = (opcode == op_reg) ? rs2_data : imm;

    always_comb begin
        case (alu_op)
            alu_sub:    alu_result = rs1_data - operand_b;
            alu_and:    alu_result = rs1_data & operand_b;
            alu_or:     alu_result = rs1_data | operand_b;
            alu_xor:    alu_result = rs1_data ^ operand_b;
            alu_pass_b: alu_result = operand_b;
            default:    alu_result = rs1_data + operand_b;
        endcase
    end

    assign rs_equal      = (rs1_data == rs2_data);
    // BEQ is funct3 000, BNE is 001
    assign branch_taken  = (opcode == op_branch) &&
                           ((inst.b.funct3 == 3'b000 && rs_equal) ||
                            (inst.b.funct3 == 3'b001 && !rs_equal));
    assign branch_target = inst_pc + imm;
    assign is_mem        = (opcode == op_load) || (opcode == op_store);
    assign writes_rd     = (opcode == op_reg || opcode == op_imm || opcode == op_lui) &&
                           (rd != '0);

    // Wait a cycle after a write or redirect so the next read sees it
    assign inst_take = (state == st_idle) && inst_valid && !wr_en && !redirect;

    //////////////////////////////////////////////////////////////////////
    // Issue and completion
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            wr_en     <= 1'b0;
            redirect  <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            redirect <= 1'b0;
            case (state)
                st_idle: begin
                    if (inst_take && is_mem) begin
                        req_valid <= 1'b1;
                        state     <= st_mem_wait;
                    end else if (inst_take) begin
                        wr_en    <= writes_rd;
                        redirect <= branch_taken;
                    end
                end
                st_mem_wait: begin
                    if (data_ack) begin
                        req_valid <= 1'b0;
                        state     <= st_idle;
                        // Only loads write back
                        wr_en     <= !req_we && (wr_addr != '0);
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inst_take) begin
            wr_addr     <= rd;
            wr_data     <= alu_result;
            req_we      <= (opcode == op_store);
            req_addr    <= alu_result;
            req_wdata   <= rs2_data;
            redirect_pc <= branch_target;
        end else if (state == st_mem_wait && data_ack) begin
            wr_data <= rdata;
        end
    end

    assign rf_wr    = '{en: wr_en, addr: wr_addr, data: wr_data};
    assign data_req = '{valid: req_valid, we: req_we, addr: req_addr, wdata: req_wdata};

    data_req_held: assert property (
        @(posedge clk) disable iff (reset)
        data_req.valid && !data_ack |=> $stable(data_req)
    );

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::mem_req_t fetch_req,
    output logic             fetch_ack,
    input  rv_pkg::mem_req_t data_req,
    output logic             data_ack,
    output rv_pkg::mem_req_t mem_req,
    input  logic             mem_ack
);

    logic busy;
    logic owner_data;

    //////////////////////////////////////////////////////////////////////
    // Owner register where the data side wins a tie
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            owner_data <= 1'b0;
        end else if (!busy) begin
            if (data_req.valid) begin
                busy       <= 1'b1;
                owner_data <= 1'b1;
            end else if (fetch_req.valid) begin
                busy       <= 1'b1;
                owner_data <= 1'b0;
            end
        end else if (mem_ack) begin
            busy <= 1'b0;
        end
    end

    // Port driven from the latched owner only
    always_comb begin
        mem_req       = owner_data ? data_req : fetch_req;
        mem_req.valid = busy && mem_req.valid;
    end

    assign fetch_ack = mem_ack && busy && !owner_data;
    assign data_ack  = mem_ack && busy && owner_data;

    ack_needs_owner: assert property (
        @(posedge clk) disable iff (reset) mem_ack |-> busy
    );

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    output rv_pkg::mem_req_t        mem_req,
    input  logic                    mem_ack,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    output rv_pkg::rf_write_t       retire
);

    import rv_pkg::*;

    // Fetch and execute requests toward the arbiter
    mem_req_t              fetch_req;
    mem_req_t              data_req;
    logic                  fetch_ack;
    logic                  data_ack;

    // Fetch buffer handshake and branch redirect
    logic                  inst_valid;
    instr_u                inst;
    logic [xlen-1:0]       inst_pc;
    logic                  inst_take;
    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;

    // Register file read ports
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_ack   (fetch_ack),
        .rdata       (mem_rdata),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_take   (inst_take),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    execute_unit u_execute (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_take   (inst_take),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rf_wr       (retire),
        .data_req    (data_req),
        .data_ack    (data_ack),
        .rdata       (mem_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    reg_file u_regs (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rf_wr    (retire)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .fetch_req (fetch_req),
        .fetch_ack (fetch_ack),
        .data_req  (data_req),
        .data_ack  (data_ack),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack)
    );

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    import rv_pkg::*;

    localparam int mem_words        = 256;
    localparam int cycles_per_entry = 40;

    logic            clk;
    logic            reset;
    mem_req_t        mem_req;
    logic            mem_ack;
    logic [xlen-1:0] mem_rdata;
    rf_write_t       retire;

    logic [xlen-1:0] mem [0:mem_words-1];
    rf_write_t       exp_writes[$];
    mem_req_t        exp_stores[$];
    int              write_idx   = 0;
    int              store_idx   = 0;
    int              acks_seen   = 0;
    int              stall_limit = 0;
    int unsigned     lcg_state   = 32'h3655;
    mem_req_t        held_req;
    logic            held_valid  = 1'b0;

    rv_core u_rv_core (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .retire    (retire)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_write(input rf_write_t observed, input rf_write_t expected);
        if (observed !== expected) begin
            $display("Mismatch at %0t ns: retire got en=%b x%0d=%h, expected en=%b x%0d=%h",
                     $time, observed.en, observed.addr, observed.data,
                     expected.en, expected.addr, expected.data);
            report_failure();
        end
    endtask

    task automatic check_store(input mem_req_t observed, input mem_req_t expected);
        if (observed !== expected) begin
            $display("Mismatch at %0t ns: mem_req got store [%h]=%h, expected store [%h]=%h",
                     $time, observed.addr, observed.wdata, expected.addr, expected.wdata);
            report_failure();
        end
    endtask

    // Tags P (address, word), R (register, value) and S (address, data)
    task automatic load_golden();
        int          fd;
        int          count;
        int          entries;
        string       line;
        byte         tag;
        logic [31:0] field_a;
        logic [31:0] field_b;
        entries = 0;
        fd = $fopen("rv_core_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open rv_core_golden.txt");
            report_failure();
        end
        while (!$feof(fd)) begin
            line  = "";
            count = $fgets(line, fd);
            if (count == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            count = $sscanf(line, "%c %h %h", tag, field_a, field_b);
            if (count != 3) begin
                $display("Malformed line in the golden file: %s", line);
                report_failure();
            end
            entries++;
            case (tag)
                "P": mem[field_a[9:2]] = field_b;
                "R": exp_writes.push_back('{en: 1'b1, addr: field_a[reg_addr_w-1:0],
                                            data: field_b});
                "S": exp_stores.push_back('{valid: 1'b1, we: 1'b1, addr: field_a,
                                            wdata: field_b});
                default: begin
                    $display("Unknown tag in the golden file: %s", line);
                    report_failure();
                end
            endcase
        end
        $fclose(fd);
        stall_limit = entries * cycles_per_entry;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, memory model and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Random latency of 1 to 4 cycles with the ack held for one cycle
    initial begin : memory_model
        int unsigned delay;
        logic [7:0]  index;
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (reset === 1'b0 && mem_req.valid) begin
                delay = 1 + (next_random() % 4);
                repeat (delay - 1) @(negedge clk);
                index     = mem_req.addr[9:2];
                mem_rdata = mem[index];
                if (mem_req.we) begin
                    mem[index] = mem_req.wdata;
                end
                mem_ack = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (stall_limit > 0);
        repeat (stall_limit) @(posedge clk);
        $display("Core stalled: expected results still missing after %0d cycles",
                 stall_limit);
        report_failure();
    end

    //////////////////////////////////////////////////////////////////////
    // Result monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset === 1'b0) begin
            if (held_valid && mem_req !== held_req) begin
                $display("mem_req changed at %0t ns while waiting for its ack", $time);
                report_failure();
            end
            if (mem_req.valid && mem_req.addr >= xlen'(mem_words * 4)) begin
                $display("Memory request to %h lies outside the model", mem_req.addr);
                report_failure();
            end
            if (acks_seen == 0 && (retire.en !== 1'b0 || (mem_req.valid && mem_req.we))) begin
                $display("Result seen at %0t ns before any memory ack", $time);
                report_failure();
            end
            if (retire.en) begin
                if (write_idx >= exp_writes.size()) begin
                    $display("Register write to x%0d beyond the expected list", retire.addr);
                    report_failure();
                end else begin
                    check_write(retire, exp_writes[write_idx]);
                    write_idx++;
                end
            end
            if (mem_req.valid && mem_req.we && mem_ack) begin
                if (store_idx >= exp_stores.size()) begin
                    $display("Store to %h beyond the expected list", mem_req.addr);
                    report_failure();
                end else begin
                    check_store(mem_req, exp_stores[store_idx]);
                    store_idx++;
                end
            end
            if (mem_ack) begin
                acks_seen++;
            end
            held_valid = mem_req.valid && !mem_ack;
            held_req   = mem_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        reset     = 1'b1;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hdead0000 | xlen'(i * 4);
        end
        load_golden();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (write_idx < exp_writes.size() || store_idx < exp_stores.size()) begin
            @(posedge clk);
        end
        // A stray write or store after the last one is still caught here
        repeat (20) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- rv_core_golden.txt
# P <address> <instruction word>, R <register> <value>, S <address> <data>
# All fields hex, R and S entries in program order
P 00 12300093
P 04 fff00113
P 08 0f017193
P 0c 7000e213
P 10 0ff24293
P 14 00408333
P 18 404083b3
P 1c 00537433
P 20 0033e4b3
P 24 00534533
P 28 123455b7
P 2c 00508013
P 30 10000613
P 34 00b62023
P 38 00a62223
P 3c 00062683
P 40 00462703
P 44 00b68663
P 48 00100793
P 4c 00200813
P 50 00a71463
P 54 00300893
P 58 00089463
P 5c 00400913
P 60 00188463
P 64 00e689b3
P 68 01362423
P 6c 00000063
R 01 00000123
R 02 ffffffff
R 03 000000f0
R 04 00000723
R 05 000007dc
R 06 00000846
R 07 fffffa00
R 08 00000044
R 09 fffffaf0
R 0a 00000f9a
R 0b 12345000
R 0c 00000100
R 0d 12345000
R 0e 00000f9a
R 11 00000003
R 13 12345f9a
S 100 12345000
S 104 00000f9a
S 108 12345f9a

//--- rv_mini.f
rv_pkg.sv
reg_file.sv
fetch_unit.sv
execute_unit.sv
mem_arbiter.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f rv_mini.f --top-module tb_rv_core -o sim_rv_core
	./obj_dir/sim_rv_core 2>&1 | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
